// File: common/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing shared by the packages, the interface and the RTL
////////////////////////////////////////////////////////////////////////////

// Data path width, one RV32I word
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Bits needed to name one register
`define REG_IDX_W 5

`endif

// File: common/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes of the supported subset
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    // Register-register arithmetic
    OP     = 7'b0110011,
    // Register-immediate arithmetic
    OP_IMM = 7'b0010011
  } opcode_e;

  // funct3 values, shared by the R and I forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 values; bit 5 selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operation, one code per instruction kind
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word, seen as R or I format
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  // Same 32 bits; the opcode picks the view
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

endpackage

// File: common/pipe_pkg.sv
`include "core_params.svh"

package pipe_pkg;

  // Decoded instruction held between ID and EX
  typedef struct packed {
    logic                  valid;
    isa_pkg::alu_op_e      alu_op;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    // Register file values as read in ID, may be stale
    logic [`XLEN-1:0]      rs1_val;
    logic [`XLEN-1:0]      rs2_val;
    // Sign-extended imm12
    logic [`XLEN-1:0]      imm;
    logic                  use_imm;
    logic [`REG_IDX_W-1:0] rd;
    logic                  regwrite;
  } id_ex_t;

  // Result record of EX/MEM, MEM/WB and WB/ID
  typedef struct packed {
    logic                  valid;
    logic                  regwrite;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      result;
  } wb_rec_t;

endpackage

// File: common/fwd_if.sv
`timescale 1ns/1ps
`include "core_params.svh"

////////////////////////////////////////////////////////////////////////////
// Result record of one younger stage, as seen by forwarding
////////////////////////////////////////////////////////////////////////////

interface fwd_if;

  // Stage holds an instruction this cycle
  logic                  valid;

  // Instruction writes rd
  logic                  regwrite;

  // Destination register
  logic [`REG_IDX_W-1:0] rd;

  // Value that goes to rd
  logic [`XLEN-1:0]      result;

  // Stage register that owns the record
  modport source (
    output valid,
    output regwrite,
    output rd,
    output result
  );

  // Forwarding and the next stage
  modport sink (
    input valid,
    input regwrite,
    input rd,
    input result
  );

endinterface

// File: src/decode/reg_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`REG_IDX_W-1:0] rd_idx_a,
  input  logic [`REG_IDX_W-1:0] rd_idx_b,
  output logic [`XLEN-1:0]      rd_data_a,
  output logic [`XLEN-1:0]      rd_data_b,
  input  logic                  wr_en,
  input  logic [`REG_IDX_W-1:0] wr_idx,
  input  logic [`XLEN-1:0]      wr_data
);

  // x1 to x31 only, x0 has no storage
  logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

  // Write at the rising edge, cleared to zero by reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Asynchronous read; x0 reads as zero
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

  // Write-back filters x0 before it gets here
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_en |-> (wr_idx != '0)
  ) else $error("reg_file: write enable with x0 as target");

endmodule

// File: src/decode/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  isa_pkg::instr_u       instr,
  output logic [`REG_IDX_W-1:0] rs1_idx,
  output logic [`REG_IDX_W-1:0] rs2_idx,
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  output pipe_pkg::id_ex_t      id_ex
);

  logic             is_op;
  logic             is_op_imm;
  isa_pkg::alu_op_e alu_op;
  logic [`XLEN-1:0] imm;
  pipe_pkg::id_ex_t id_ex_d;

  ////////////////////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////////////////////

  // Opcode sits in the same bits in both views
  assign is_op     = (instr.r.opcode == isa_pkg::OP);
  assign is_op_imm = (instr.i.opcode == isa_pkg::OP_IMM);

  assign rs1_idx = instr.i.rs1;
  // I-type has no rs2; zero keeps forwarding quiet on that side
  assign rs2_idx = is_op ? instr.r.rs2 : '0;

  // Sign-extended 12-bit immediate
  assign imm = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

  // funct3 picks the operation
  // funct7 bit 5 selects SUB (R only) and SRA / SRAI
  always_comb begin
    case (instr.r.funct3)
      isa_pkg::F3_ADD_SUB: begin
        alu_op = (is_op && (instr.r.funct7 == isa_pkg::F7_ALT)) ?
                 isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      end
      isa_pkg::F3_SLL:  alu_op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  alu_op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: alu_op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  alu_op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: begin
        // SRAI carries the same funct7 in the top of imm12
        alu_op = (instr.r.funct7 == isa_pkg::F7_BASE) ?
                 isa_pkg::ALU_SRL : isa_pkg::ALU_SRA;
      end
      isa_pkg::F3_OR:   alu_op = isa_pkg::ALU_OR;
      default:          alu_op = isa_pkg::ALU_AND;
    endcase
  end

  // Next ID/EX record
  always_comb begin
    id_ex_d.valid    = instr_valid;
    id_ex_d.alu_op   = alu_op;
    id_ex_d.rs1_idx  = rs1_idx;
    id_ex_d.rs2_idx  = rs2_idx;
    id_ex_d.rs1_val  = rs1_data;
    id_ex_d.rs2_val  = rs2_data;
    id_ex_d.imm      = imm;
    id_ex_d.use_imm  = is_op_imm;
    id_ex_d.rd       = instr.r.rd;
    // Every supported operation writes rd
    id_ex_d.regwrite = instr_valid && (is_op || is_op_imm);
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

  // Only OP and OP_IMM are ever issued
  a_supported_opcode : assert property (
    @(posedge clk) disable iff (!arst_n)
    instr_valid |-> (is_op || is_op_imm)
  ) else $error("decode_stage: unsupported opcode %b", instr.r.opcode);

endmodule

// File: src/execute/operand_forward.sv
`timescale 1ns/1ps
`include "core_params.svh"

module operand_forward (
  input  pipe_pkg::id_ex_t id_ex,
  fwd_if.sink              ex_mem,
  fwd_if.sink              mem_wb,
  fwd_if.sink              wb_id,
  output logic [`XLEN-1:0] op_a,
  output logic [`XLEN-1:0] op_b
);

  // Younger stages by priority, 0 = EX/MEM, 1 = MEM/WB, 2 = WB/ID
  logic [2:0]            stage_en;
  logic [`REG_IDX_W-1:0] stage_rd  [3];
  logic [`XLEN-1:0]      stage_res [3];
  logic [`XLEN-1:0]      fwd_rs2;

  ////////////////////////////////////////////////////////////////////////////
  // Collect the three result records
  ////////////////////////////////////////////////////////////////////////////

  assign stage_en[0]  = ex_mem.valid && ex_mem.regwrite;
  assign stage_rd[0]  = ex_mem.rd;
  assign stage_res[0] = ex_mem.result;

  assign stage_en[1]  = mem_wb.valid && mem_wb.regwrite;
  assign stage_rd[1]  = mem_wb.rd;
  assign stage_res[1] = mem_wb.result;

  // WB/ID covers the write that lands in the same edge as the ID read
  assign stage_en[2]  = wb_id.valid && wb_id.regwrite;
  assign stage_rd[2]  = wb_id.rd;
  assign stage_res[2] = wb_id.result;

  // Walks oldest to youngest, so the nearest producer wins
  // Source x0 keeps its register file zero
  function automatic logic [`XLEN-1:0] forward_src(
    input logic [`REG_IDX_W-1:0] src,
    input logic [`XLEN-1:0]      reg_val
  );
    logic [`XLEN-1:0] val;
    val = reg_val;
    for (int s = 2; s >= 0; s--) begin
      if ((src != '0) && stage_en[s] && (stage_rd[s] == src)) begin
        val = stage_res[s];
      end
    end
    return val;
  endfunction

  always_comb begin
    op_a    = forward_src(id_ex.rs1_idx, id_ex.rs1_val);
    fwd_rs2 = forward_src(id_ex.rs2_idx, id_ex.rs2_val);
    // Immediate replaces rs2 for OP_IMM
    op_b    = id_ex.use_imm ? id_ex.imm : fwd_rs2;
  end

  // A live operand never carries X, whatever stage it came from
  always_comb begin
    if (id_ex.valid) begin
      a_operands_known : assert (!$isunknown({op_a, op_b}))
        else $error("operand_forward: unknown operand, rs1=%0d rs2=%0d",
                    id_ex.rs1_idx, id_ex.rs2_idx);
    end
  end

endmodule

// File: src/execute/alu_execute.sv
`timescale 1ns/1ps
`include "core_params.svh"

module alu_execute (
  input  logic             clk,
  input  logic             arst_n,
  input  pipe_pkg::id_ex_t id_ex,
  input  logic [`XLEN-1:0] op_a,
  input  logic [`XLEN-1:0] op_b,
  fwd_if.source            ex_mem
);

  logic [4:0]        shamt;
  logic [`XLEN-1:0]  alu_res;
  pipe_pkg::wb_rec_t ex_mem_q;

  // Shift amount, low five bits of the second operand
  assign shamt = op_b[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.alu_op)
      isa_pkg::ALU_ADD:  alu_res = op_a + op_b;
      isa_pkg::ALU_SUB:  alu_res = op_a - op_b;
      isa_pkg::ALU_SLL:  alu_res = op_a << shamt;
      // Compare results are zero-extended to the full word
      isa_pkg::ALU_SLT: begin
        alu_res = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      isa_pkg::ALU_SLTU: begin
        alu_res = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
      end
      isa_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      isa_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      // Arithmetic shift copies the sign bit in
      isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      isa_pkg::ALU_OR:   alu_res = op_a | op_b;
      default:           alu_res = op_a & op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q.valid    <= id_ex.valid;
      ex_mem_q.regwrite <= id_ex.regwrite;
      ex_mem_q.rd       <= id_ex.rd;
      ex_mem_q.result   <= alu_res;
    end
  end

  // Record out to forwarding and the result pipe
  assign ex_mem.valid    = ex_mem_q.valid;
  assign ex_mem.regwrite = ex_mem_q.regwrite;
  assign ex_mem.rd       = ex_mem_q.rd;
  assign ex_mem.result   = ex_mem_q.result;

endmodule

// File: src/result/result_pipe.sv
`timescale 1ns/1ps
`include "core_params.svh"

module result_pipe (
  input  logic                  clk,
  input  logic                  arst_n,
  fwd_if.sink                   ex_mem,
  fwd_if.source                 mem_wb,
  fwd_if.source                 wb_id,
  output logic                  wr_en,
  output logic [`REG_IDX_W-1:0] wr_idx,
  output logic [`XLEN-1:0]      wr_data,
  output logic                  retire_valid,
  output logic [`REG_IDX_W-1:0] retire_rd,
  output logic [`XLEN-1:0]      retire_data
);

  pipe_pkg::wb_rec_t mem_wb_q;
  pipe_pkg::wb_rec_t wb_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB and WB/ID registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb_q <= '0;
      wb_id_q  <= '0;
    end else begin
      mem_wb_q.valid    <= ex_mem.valid;
      mem_wb_q.regwrite <= ex_mem.regwrite;
      mem_wb_q.rd       <= ex_mem.rd;
      mem_wb_q.result   <= ex_mem.result;
      // Kept one more cycle, after the register file took it
      wb_id_q           <= mem_wb_q;
    end
  end

  assign mem_wb.valid    = mem_wb_q.valid;
  assign mem_wb.regwrite = mem_wb_q.regwrite;
  assign mem_wb.rd       = mem_wb_q.rd;
  assign mem_wb.result   = mem_wb_q.result;

  assign wb_id.valid     = wb_id_q.valid;
  assign wb_id.regwrite  = wb_id_q.regwrite;
  assign wb_id.rd        = wb_id_q.rd;
  assign wb_id.result    = wb_id_q.result;

  // Register file write; x0 targets retire but are not written
  assign wr_en   = mem_wb_q.valid && mem_wb_q.regwrite && (mem_wb_q.rd != '0);
  assign wr_idx  = mem_wb_q.rd;
  assign wr_data = mem_wb_q.result;

  // Retire port shows the same MEM/WB record
  assign retire_valid = mem_wb_q.valid;
  assign retire_rd    = mem_wb_q.rd;
  assign retire_data  = mem_wb_q.result;

endmodule

// File: src/int_pipe_top.sv
`timescale 1ns/1ps
`include "core_params.svh"

module int_pipe_top (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output logic        retire_valid,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data
);

  logic [`REG_IDX_W-1:0] rs1_idx;
  logic [`REG_IDX_W-1:0] rs2_idx;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  pipe_pkg::id_ex_t      id_ex;
  logic [`XLEN-1:0]      op_a;
  logic [`XLEN-1:0]      op_b;
  logic                  wr_en;
  logic [`REG_IDX_W-1:0] wr_idx;
  logic [`XLEN-1:0]      wr_data;

  // Result records of the three younger stages
  fwd_if ex_mem_fwd ();
  fwd_if mem_wb_fwd ();
  fwd_if wb_id_fwd ();

  ////////////////////////////////////////////////////////////////////////////
  // ID
  ////////////////////////////////////////////////////////////////////////////

  decode_stage u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_ex       (id_ex)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (rs1_idx),
    .rd_idx_b  (rs2_idx),
    .rd_data_a (rs1_data),
    .rd_data_b (rs2_data),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // EX
  ////////////////////////////////////////////////////////////////////////////

  operand_forward u_forward (
    .id_ex  (id_ex),
    .ex_mem (ex_mem_fwd),
    .mem_wb (mem_wb_fwd),
    .wb_id  (wb_id_fwd),
    .op_a   (op_a),
    .op_b   (op_b)
  );

  alu_execute u_alu (
    .clk    (clk),
    .arst_n (arst_n),
    .id_ex  (id_ex),
    .op_a   (op_a),
    .op_b   (op_b),
    .ex_mem (ex_mem_fwd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB, WB/ID and retire
  ////////////////////////////////////////////////////////////////////////////

  result_pipe u_result (
    .clk          (clk),
    .arst_n       (arst_n),
    .ex_mem       (ex_mem_fwd),
    .mem_wb       (mem_wb_fwd),
    .wb_id        (wb_id_fwd),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

// File: test/int_pipe_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module int_pipe_tb;

  // Operation kinds of the model, R-type first
  localparam int K_ADD   = 0;
  localparam int K_SUB   = 1;
  localparam int K_AND   = 2;
  localparam int K_OR    = 3;
  localparam int K_XOR   = 4;
  localparam int K_SLT   = 5;
  localparam int K_SLTU  = 6;
  localparam int K_SLL   = 7;
  localparam int K_SRL   = 8;
  localparam int K_SRA   = 9;
  localparam int K_ADDI  = 10;
  localparam int K_ANDI  = 11;
  localparam int K_ORI   = 12;
  localparam int K_XORI  = 13;
  localparam int K_SLTI  = 14;
  localparam int K_SLTIU = 15;
  localparam int K_SLLI  = 16;
  localparam int K_SRLI  = 17;
  localparam int K_SRAI  = 18;

  localparam int N_DIRECTED  = 37;
  localparam int N_RANDOM    = 300;
  localparam int CYCLE_LIMIT = 40 + N_DIRECTED + N_RANDOM + 3;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      data;
  } retire_rec_t;

  logic                  clk;
  logic                  arst_n;
  logic                  instr_valid;
  logic [31:0]           instr;
  logic                  retire_valid;
  logic [4:0]            retire_rd;
  logic [31:0]           retire_data;

  // Golden register state, updated in issue order
  logic [`XLEN-1:0]      gold [`REG_COUNT];
  retire_rec_t           exp_q [$];
  logic                  exp_pending;
  logic [`REG_IDX_W-1:0] exp_rd;
  logic [`XLEN-1:0]      exp_data;
  logic                  retire_seen;
  // Issue strobe as sampled at each of the last three rising edges
  logic [2:0]            issue_hist;
  integer                seed;
  int                    cycle_count = 0;

  int_pipe_top dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("ERROR at %0t ns: %s expected 0x%08h actual 0x%08h",
                        $time, name, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and encoder
  ////////////////////////////////////////////////////////////////////////////

  // Result of one operation by the RV32I rules
  function automatic logic [31:0] model_result(input int kind, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (kind)
      K_ADD, K_ADDI:   r = a + b;
      K_SUB:           r = a - b;
      K_AND, K_ANDI:   r = a & b;
      K_OR, K_ORI:     r = a | b;
      K_XOR, K_XORI:   r = a ^ b;
      K_SLT, K_SLTI:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLTU, K_SLTIU: r = (a < b) ? 32'd1 : 32'd0;
      K_SLL, K_SLLI:   r = a << sh;
      K_SRL, K_SRLI:   r = a >> sh;
      default: begin
        // Vacated top bits take the sign
        r = a >> sh;
        if (a[31]) begin
          r = r | ~(32'hffff_ffff >> sh);
        end
      end
    endcase
    return r;
  endfunction

  // funct3 straight from the ISA tables
  function automatic logic [2:0] funct3_of(input int kind);
    case (kind)
      K_ADD, K_SUB, K_ADDI:          return 3'b000;
      K_SLL, K_SLLI:                 return 3'b001;
      K_SLT, K_SLTI:                 return 3'b010;
      K_SLTU, K_SLTIU:               return 3'b011;
      K_XOR, K_XORI:                 return 3'b100;
      K_SRL, K_SRA, K_SRLI, K_SRAI:  return 3'b101;
      K_OR, K_ORI:                   return 3'b110;
      default:                       return 3'b111;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_instr(input logic [31:0] word);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = word;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      instr       = '0;
    end
  endtask

  // Encodes, issues and predicts one instruction
  task automatic issue_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] imm);
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [11:0]     imm12;
    isa_pkg::instr_u word;
    retire_rec_t     rec;
    a = gold[rs1];
    if (kind < K_ADDI) begin
      b                = gold[rs2];
      word.r.funct7    = (kind == K_SUB || kind == K_SRA) ? 7'b0100000 : 7'b0000000;
      word.r.rs2       = rs2;
      word.r.rs1       = rs1;
      word.r.funct3    = funct3_of(kind);
      word.r.rd        = rd;
      word.r.opcode    = isa_pkg::OP;
    end else begin
      imm12 = imm;
      // Shift immediates hold funct7 above shamt
      if (kind == K_SLLI || kind == K_SRLI) begin
        imm12 = {7'b0000000, imm[4:0]};
      end
      if (kind == K_SRAI) begin
        imm12 = {7'b0100000, imm[4:0]};
      end
      b             = {{20{imm12[11]}}, imm12};
      word.i.imm12  = imm12;
      word.i.rs1    = rs1;
      word.i.funct3 = funct3_of(kind);
      word.i.rd     = rd;
      word.i.opcode = isa_pkg::OP_IMM;
    end
    res = model_result(kind, a, b);
    drive_instr(word);
    // x0 keeps zero but the write still retires
    if (rd != 5'd0) begin
      gold[rd] = res;
    end
    rec.rd   = rd;
    rec.data = res;
    exp_q.push_back(rec);
  endtask

  task automatic issue_r(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2);
    issue_instr(kind, rd, rs1, rs2, 12'h000);
  endtask

  task automatic issue_i(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
    issue_instr(kind, rd, rs1, 5'd0, imm);
  endtask

  task automatic run_directed();
    // Dependences at distance 1, 2 and 3
    issue_i(K_ADDI, 5'd1, 5'd0, 12'h005);
    issue_i(K_ADDI, 5'd2, 5'd0, 12'hffd);
    issue_r(K_ADD, 5'd3, 5'd1, 5'd2);
    issue_i(K_XORI, 5'd7, 5'd0, 12'h7ff);
    issue_r(K_SUB, 5'd4, 5'd3, 5'd1);
    issue_i(K_ADDI, 5'd8, 5'd0, 12'h001);
    issue_i(K_ADDI, 5'd9, 5'd0, 12'h002);
    issue_r(K_OR, 5'd5, 5'd3, 5'd4);
    // Same register in several stages at once
    issue_i(K_ADDI, 5'd10, 5'd0, 12'h00b);
    issue_i(K_ADDI, 5'd10, 5'd0, 12'h016);
    issue_i(K_ADDI, 5'd10, 5'd0, 12'h021);
    issue_r(K_ADD, 5'd11, 5'd10, 5'd10);
    issue_i(K_ADDI, 5'd12, 5'd0, 12'h02c);
    issue_i(K_ADDI, 5'd12, 5'd0, 12'h037);
    issue_i(K_ADDI, 5'd13, 5'd0, 12'h001);
    issue_i(K_SLLI, 5'd14, 5'd12, 12'h002);
    // Writes to x0 then reads of x0
    issue_i(K_ADDI, 5'd0, 5'd1, 12'h009);
    issue_r(K_ADD, 5'd15, 5'd0, 5'd1);
    issue_i(K_ADDI, 5'd0, 5'd0, 12'hfff);
    issue_r(K_SUB, 5'd16, 5'd0, 5'd0);
    issue_i(K_ORI, 5'd17, 5'd0, 12'h000);
    // Signed against unsigned, logical against arithmetic
    issue_i(K_ADDI, 5'd18, 5'd0, 12'hfff);
    issue_r(K_SLT, 5'd19, 5'd18, 5'd1);
    issue_r(K_SLTU, 5'd20, 5'd18, 5'd1);
    issue_i(K_SLTI, 5'd21, 5'd18, 12'h000);
    issue_i(K_SLTIU, 5'd22, 5'd1, 12'hfff);
    issue_i(K_SRAI, 5'd23, 5'd18, 12'h004);
    issue_i(K_SLLI, 5'd24, 5'd2, 12'h01c);
    issue_r(K_SRA, 5'd25, 5'd24, 5'd1);
    issue_r(K_SRL, 5'd26, 5'd24, 5'd1);
    issue_i(K_SRLI, 5'd27, 5'd24, 12'h01f);
    issue_r(K_AND, 5'd28, 5'd24, 5'd18);
    issue_r(K_XOR, 5'd29, 5'd24, 5'd2);
    issue_i(K_ANDI, 5'd30, 5'd24, 12'hf00);
    // Gaps in the issue stream
    idle_cycles(2);
    issue_r(K_ADD, 5'd31, 5'd30, 5'd29);
    idle_cycles(1);
    issue_i(K_ADDI, 5'd1, 5'd31, 12'h001);
    idle_cycles(3);
    issue_r(K_ADD, 5'd2, 5'd1, 5'd1);
  endtask

  task automatic run_random(input int count);
    logic [31:0] pick;
    logic [31:0] regs;
    int          kind;
    repeat (count) begin
      pick = $random(seed);
      regs = $random(seed);
      kind = int'(pick[15:0]) % 19;
      // x0 to x7 only, so hazards and x0 writes come often
      issue_instr(kind, {2'b00, regs[2:0]}, {2'b00, regs[5:3]}, {2'b00, regs[8:6]},
                  regs[31:20]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected retire tracking and checks
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    retire_seen <= retire_valid;
  end

  // Retire is due three edges after the issue edge
  always @(posedge clk) begin
    issue_hist <= {issue_hist[1:0], instr_valid};
  end

  // Head moves on once its retire has been checked
  always @(posedge clk) begin
    #2;
    if (retire_seen) begin
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
    exp_pending = (exp_q.size() != 0);
    if (exp_pending) begin
      exp_rd   = exp_q[0].rd;
      exp_data = exp_q[0].data;
    end
  end

  a_retire_latency : assert property (
    @(negedge clk) disable iff (!arst_n)
    retire_valid == issue_hist[2]
  ) else report_mismatch("retire_valid", {31'd0, issue_hist[2]}, {31'd0, retire_valid});

  a_retire_expected : assert property (
    @(negedge clk) disable iff (!arst_n)
    retire_valid |-> exp_pending
  ) else abort_run("A retire came out with no instruction outstanding");

  a_retire_rd : assert property (
    @(negedge clk) disable iff (!arst_n)
    (retire_valid && exp_pending) |-> (retire_rd == exp_rd)
  ) else report_mismatch("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd});

  a_retire_data : assert property (
    @(negedge clk) disable iff (!arst_n)
    (retire_valid && exp_pending) |-> (retire_data == exp_data)
  ) else report_mismatch("retire_data", exp_data, retire_data);

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout after %0d cycles, %0d retires still outstanding",
                          cycle_count, exp_q.size()));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 32'hf15e2606;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_pending = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    retire_seen = 1'b0;
    issue_hist  = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      gold[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // Quiet pipe before the first issue
    idle_cycles(3);
    run_directed();
    run_random(N_RANDOM);
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // A few quiet cycles catch any retire beyond the last one
    idle_cycles(3);
    $display("Test OK");
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
common/fwd_if.sv
src/decode/reg_file.sv
src/decode/decode_stage.sv
src/execute/operand_forward.sv
src/execute/alu_execute.sv
src/result/result_pipe.sv
src/int_pipe_top.sv
test/int_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module int_pipe_tb -o int_pipe_sim \
  && ./obj_dir/int_pipe_sim | grep -F "Test OK" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
